//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_cpu_core
FLIST    := flist.f
OBJ_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := Testbench passed

SRCS := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SRCS)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
rtl/cpu_pkg.sv
rtl/microcode_store.sv
rtl/register_file.sv
rtl/exec_unit.sv
rtl/control_logic.sv
rtl/cpu_core.sv
test/tb_cpu_core.sv

//--- rtl/control_logic.sv
`timescale 1ns/1ps

module control_logic (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [cpu_pkg::opcode_width-1:0]     opcode,
  // Bootstrap side of the microcode store
  input  logic [cpu_pkg::boot_addr_width-1:0]  boot_addr,
  input  logic [cpu_pkg::data_width-1:0]       boot_data,
  input  logic                                 boot_we_n,
  input  logic                                 n_booted,
  // Register file addressing
  output logic [cpu_pkg::reg_src_width-1:0]    reg_src,
  output cpu_pkg::reg_sel_e                    reg_sel,
  output logic [cpu_pkg::alu_plane_width-1:0]  alu_plane,
  // Out plane
  output logic                                 reg_oe,
  output logic                                 tmp0_oe,
  output logic                                 tmp1_oe,
  output logic                                 mlu_oe,
  output logic                                 shifter_oe,
  output logic                                 ext_oe,
  output logic                                 opword_oe,
  // In plane
  output logic                                 reg_load,
  output logic                                 tmp0_load,
  output logic                                 tmp1_load,
  output logic                                 opword_load,
  output logic                                 opcode_load,
  output logic                                 out_load
);

  logic [cpu_pkg::step_width-1:0]  step;
  logic [cpu_pkg::uword_width-1:0] uword;
  logic [cpu_pkg::ctrl_width-1:0]  ctrl;
  logic                            step_clr;

  cpu_pkg::in_plane_e  in_sel;
  cpu_pkg::out_plane_e out_sel;

  // Store is addressed by opcode in the high bits and step below
  microcode_store i_store (
    .clk       (clk),
    .addr      ({opcode, step}),
    .boot_addr (boot_addr),
    .boot_data (boot_data),
    .boot_we_n (boot_we_n),
    .n_booted  (n_booted),
    .uword     (uword)
  );

  // Misc plane has a single meaning for now
  assign step_clr = ctrl[cpu_pkg::misc_bit];

  // Micro-op counter
  // Held at zero until boot completes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= '0;
    end else if (n_booted || step_clr) begin
      step <= '0;
    end else begin
      step <= step + 1'b1;
    end
  end

  // Control word taken in the middle of the cycle
  // Lets the store output settle before the next rising edge uses it
  always_ff @(negedge clk) begin
    if (!rst_n) begin
      ctrl <= '0;
    end else begin
      ctrl <= uword[cpu_pkg::ctrl_width-1:0];
    end
  end

  // Field split
  assign reg_src   = ctrl[cpu_pkg::reg_src_lsb +: cpu_pkg::reg_src_width];
  assign reg_sel   = cpu_pkg::reg_sel_e'(ctrl[cpu_pkg::reg_sel_lsb +: cpu_pkg::reg_sel_width]);
  assign alu_plane = ctrl[cpu_pkg::alu_plane_lsb +: cpu_pkg::alu_plane_width];
  assign in_sel    = cpu_pkg::in_plane_e'(ctrl[cpu_pkg::in_plane_lsb +: cpu_pkg::in_plane_width]);
  assign out_sel   = cpu_pkg::out_plane_e'(
    ctrl[cpu_pkg::out_plane_lsb +: cpu_pkg::out_plane_width]);

  // In plane decoder, plain levels sampled at the rising edge
  assign reg_load    = (in_sel == cpu_pkg::IN_REG);
  assign tmp0_load   = (in_sel == cpu_pkg::IN_TMP0);
  assign tmp1_load   = (in_sel == cpu_pkg::IN_TMP1);
  assign opword_load = (in_sel == cpu_pkg::IN_OPWORD);
  assign opcode_load = (in_sel == cpu_pkg::IN_OPCODE);
  assign out_load    = (in_sel == cpu_pkg::IN_OUTPORT);

  // Out plane decoder
  // One code per driver so at most one select is ever high
  assign reg_oe     = (out_sel == cpu_pkg::OUT_REG);
  assign tmp0_oe    = (out_sel == cpu_pkg::OUT_TMP0);
  assign tmp1_oe    = (out_sel == cpu_pkg::OUT_TMP1);
  assign mlu_oe     = (out_sel == cpu_pkg::OUT_MLU);
  assign shifter_oe = (out_sel == cpu_pkg::OUT_SHIFTER);
  assign ext_oe     = (out_sel == cpu_pkg::OUT_EXT);
  assign opword_oe  = (out_sel == cpu_pkg::OUT_OPWORD);

  // Bad register selector in the loaded microcode
  a_reg_sel_valid: assert property (
    @(posedge clk) disable iff (!rst_n) reg_sel != 2'd3
  ) else $error("control_logic: reg_sel code 3 in microcode");

  // A target never feeds itself through the bus
  a_no_self_transfer: assert property (
    @(posedge clk) disable iff (!rst_n)
      !((reg_load && reg_oe) || (tmp0_load && tmp0_oe) ||
        (tmp1_load && tmp1_oe) || (opword_load && opword_oe))
  ) else $error("control_logic: load and drive of the same target");

  a_no_asl: assert property (
    @(posedge clk) disable iff (!rst_n)
      shifter_oe |-> (alu_plane[1:0] != cpu_pkg::SH_ASL)
  ) else $error("control_logic: SH_ASL on the bus");

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core #(
  parameter int num_regs = 4
) (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic [cpu_pkg::data_width-1:0]       ext_data,
  input  logic [cpu_pkg::boot_addr_width-1:0]  boot_addr,
  input  logic [cpu_pkg::data_width-1:0]       boot_data,
  input  logic                                 boot_we_n,
  input  logic                                 n_booted,
  output logic                                 ext_rd,
  output logic [cpu_pkg::data_width-1:0]       out_data,
  output logic                                 out_valid
);

  localparam int dw = cpu_pkg::data_width;

  logic [dw-1:0] bus;
  logic [dw-1:0] tmp0;
  logic [dw-1:0] tmp1;
  logic [dw-1:0] opword;
  logic [dw-1:0] rd_data;
  logic [dw-1:0] mlu_out;
  logic [dw-1:0] shift_out;
  logic [cpu_pkg::opcode_width-1:0] opcode;

  logic [cpu_pkg::reg_src_width-1:0]   reg_src;
  cpu_pkg::reg_sel_e                   reg_sel;
  logic [cpu_pkg::alu_plane_width-1:0] alu_plane;

  logic reg_oe, tmp0_oe, tmp1_oe, mlu_oe, shifter_oe, ext_oe, opword_oe;
  logic reg_load, tmp0_load, tmp1_load, opword_load, opcode_load, out_load;

  control_logic i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .opcode      (opcode),
    .boot_addr   (boot_addr),
    .boot_data   (boot_data),
    .boot_we_n   (boot_we_n),
    .n_booted    (n_booted),
    .reg_src     (reg_src),
    .reg_sel     (reg_sel),
    .alu_plane   (alu_plane),
    .reg_oe      (reg_oe),
    .tmp0_oe     (tmp0_oe),
    .tmp1_oe     (tmp1_oe),
    .mlu_oe      (mlu_oe),
    .shifter_oe  (shifter_oe),
    .ext_oe      (ext_oe),
    .opword_oe   (opword_oe),
    .reg_load    (reg_load),
    .tmp0_load   (tmp0_load),
    .tmp1_load   (tmp1_load),
    .opword_load (opword_load),
    .opcode_load (opcode_load),
    .out_load    (out_load)
  );

  register_file #(.num_regs(num_regs)) i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (reg_load),
    .opcode  (opcode),
    .reg_sel (reg_sel),
    .reg_src (reg_src),
    .bus_in  (bus),
    .rd_data (rd_data)
  );

  exec_unit i_exec (
    .tmp0       (tmp0),
    .tmp1       (tmp1),
    .alu_plane  (alu_plane),
    .shifter_oe (shifter_oe),
    .mlu_out    (mlu_out),
    .shift_out  (shift_out)
  );

  // Wired-OR bus, an idle bus reads as zero
  assign bus = ({dw{reg_oe}}     & rd_data)   |
               ({dw{tmp0_oe}}    & tmp0)      |
               ({dw{tmp1_oe}}    & tmp1)      |
               ({dw{mlu_oe}}     & mlu_out)   |
               ({dw{shifter_oe}} & shift_out) |
               ({dw{ext_oe}}     & ext_data)  |
               ({dw{opword_oe}}  & opword);

  // External byte is taken at the edge that ends this cycle
  assign ext_rd = ext_oe;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tmp0      <= '0;
      tmp1      <= '0;
      opword    <= '0;
      opcode    <= '0;
      out_valid <= 1'b0;
    end else begin
      if (tmp0_load) tmp0 <= bus;
      if (tmp1_load) tmp1 <= bus;
      if (opword_load) opword <= bus;
      // Opcode is the low bits of the bus
      if (opcode_load) opcode <= bus[cpu_pkg::opcode_width-1:0];
      out_valid <= out_load;
    end
  end

  // Output byte, valid flag marks the cycle after the load
  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= bus;
    end
  end

  a_one_bus_driver: assert property (
    @(posedge clk) disable iff (!rst_n)
      $onehot0({reg_oe, tmp0_oe, tmp1_oe, mlu_oe, shifter_oe, ext_oe, opword_oe})
  ) else $error("cpu_core: more than one bus driver enabled");

endmodule

//--- rtl/cpu_pkg.sv
package cpu_pkg;

  // Bus and microcode geometry
  localparam int data_width      = 8;
  localparam int opcode_width    = 6;
  localparam int step_width      = 5;
  localparam int uaddr_width     = opcode_width + step_width;
  localparam int uword_width     = 32;
  // Boot address is word address with a byte lane below it
  localparam int lane_width      = 2;
  localparam int boot_addr_width = uaddr_width + lane_width;

  // Control word fields, counted from bit 0 upward
  localparam int reg_src_lsb     = 0;
  localparam int reg_src_width   = 2;
  localparam int reg_sel_lsb     = 2;
  localparam int reg_sel_width   = 2;
  localparam int alu_plane_lsb   = 4;
  localparam int alu_plane_width = 4;
  localparam int out_plane_lsb   = 8;
  localparam int out_plane_width = 3;
  localparam int in_plane_lsb    = 11;
  localparam int in_plane_width  = 3;
  localparam int misc_bit        = 14;
  // Bits above this are reserved and never latched
  localparam int ctrl_width      = 15;

  // Load targets
  typedef enum logic [2:0] {
    IN_NONE, IN_REG, IN_TMP0, IN_TMP1, IN_OPWORD, IN_OPCODE, IN_OUTPORT
  } in_plane_e;

  // Bus drivers
  typedef enum logic [2:0] {
    OUT_NONE, OUT_REG, OUT_TMP0, OUT_TMP1, OUT_MLU, OUT_SHIFTER, OUT_EXT, OUT_OPWORD
  } out_plane_e;

  // Register index source, code 3 is not allowed
  typedef enum logic [1:0] {
    SEL_OP0, SEL_OP1, SEL_SRC
  } reg_sel_e;

  typedef enum logic [2:0] {
    MLU_ADD, MLU_SUB, MLU_AND, MLU_OR, MLU_XOR, MLU_NOT, MLU_PASS, MLU_INC
  } mlu_op_e;

  // Arithmetic left shift has no meaning here
  typedef enum logic [1:0] {
    SH_LSL, SH_LSR, SH_ASR, SH_ASL
  } shift_op_e;

endpackage

//--- rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic [cpu_pkg::data_width-1:0]       tmp0,
  input  logic [cpu_pkg::data_width-1:0]       tmp1,
  input  logic [cpu_pkg::alu_plane_width-1:0]  alu_plane,
  input  logic                                 shifter_oe,
  output logic [cpu_pkg::data_width-1:0]       mlu_out,
  output logic [cpu_pkg::data_width-1:0]       shift_out
);

  localparam int msb = cpu_pkg::data_width - 1;

  cpu_pkg::mlu_op_e   mlu_op;
  cpu_pkg::shift_op_e sh_op;
  logic               cin;
  logic [msb:0]       cin_ext;

  // ALU plane shared by both units
  // MLU reads op from bits 3:1, shifter reads bits 1:0
  assign mlu_op  = cpu_pkg::mlu_op_e'(alu_plane[3:1]);
  assign cin     = alu_plane[0];
  assign sh_op   = cpu_pkg::shift_op_e'(alu_plane[1:0]);
  assign cin_ext = {{msb{1'b0}}, cin};

  // MLU, carry out is dropped
  always_comb begin
    case (mlu_op)
      cpu_pkg::MLU_ADD:  mlu_out = tmp0 + tmp1 + cin_ext;
      // Subtract as add of the complement, cin=1 gives a true difference
      cpu_pkg::MLU_SUB:  mlu_out = tmp0 + ~tmp1 + cin_ext;
      cpu_pkg::MLU_AND:  mlu_out = tmp0 & tmp1;
      cpu_pkg::MLU_OR:   mlu_out = tmp0 | tmp1;
      cpu_pkg::MLU_XOR:  mlu_out = tmp0 ^ tmp1;
      cpu_pkg::MLU_NOT:  mlu_out = ~tmp0;
      cpu_pkg::MLU_PASS: mlu_out = tmp0;
      cpu_pkg::MLU_INC:  mlu_out = tmp0 + 1'b1;
      default:           mlu_out = tmp0;
    endcase
  end

  // Single-bit shifter on TMP0
  always_comb begin
    case (sh_op)
      cpu_pkg::SH_LSL: shift_out = {tmp0[msb-1:0], 1'b0};
      cpu_pkg::SH_LSR: shift_out = {1'b0, tmp0[msb:1]};
      // Sign bit copied down
      cpu_pkg::SH_ASR: shift_out = {tmp0[msb], tmp0[msb:1]};
      // ASL falls back to a plain left shift
      default:         shift_out = {tmp0[msb-1:0], 1'b0};
    endcase
  end

  // Checked here so a bad word is flagged at the unit it would reach
  always_comb begin
    if (shifter_oe) begin
      assert (sh_op != cpu_pkg::SH_ASL)
        else $error("exec_unit: arithmetic left shift selected");
    end
  end

endmodule

//--- rtl/microcode_store.sv
`timescale 1ns/1ps

module microcode_store (
  input  logic                                 clk,
  input  logic [cpu_pkg::uaddr_width-1:0]      addr,
  input  logic [cpu_pkg::boot_addr_width-1:0]  boot_addr,
  input  logic [cpu_pkg::data_width-1:0]       boot_data,
  input  logic                                 boot_we_n,
  input  logic                                 n_booted,
  output logic [cpu_pkg::uword_width-1:0]      uword
);

  localparam int depth = 2 ** cpu_pkg::uaddr_width;

  logic [cpu_pkg::uword_width-1:0] mem [depth];

  // Word and lane picked out of the boot address
  logic [cpu_pkg::uaddr_width-1:0] boot_word;
  logic [cpu_pkg::lane_width-1:0]  boot_lane;

  assign boot_word = boot_addr[cpu_pkg::boot_addr_width-1:cpu_pkg::lane_width];
  assign boot_lane = boot_addr[cpu_pkg::lane_width-1:0];

  // One byte per clock, lane 0 holds bits 7:0
  always_ff @(posedge clk) begin
    if (!boot_we_n) begin
      mem[boot_word][{boot_lane, 3'b000} +: cpu_pkg::data_width] <= boot_data;
    end
  end

  // Read is combinational
  // Output stays quiet until the boot loader is done
  assign uword = n_booted ? '0 : mem[addr];

  // Microcode is frozen once the core is running
  a_no_write_after_boot: assert property (
    @(posedge clk) !n_booted |-> boot_we_n
  ) else $error("microcode_store: bootstrap write after boot");

endmodule

//--- rtl/register_file.sv
`timescale 1ns/1ps

module register_file #(
  parameter int num_regs = 4
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                load,
  input  logic [cpu_pkg::opcode_width-1:0]    opcode,
  input  cpu_pkg::reg_sel_e                   reg_sel,
  input  logic [cpu_pkg::reg_src_width-1:0]   reg_src,
  input  logic [cpu_pkg::data_width-1:0]      bus_in,
  output logic [cpu_pkg::data_width-1:0]      rd_data
);

  logic [cpu_pkg::data_width-1:0]    regs [num_regs];
  logic [cpu_pkg::reg_src_width-1:0] idx;

  // Register index comes from the instruction or from microcode
  always_comb begin
    case (reg_sel)
      cpu_pkg::SEL_OP0: idx = opcode[1:0];
      cpu_pkg::SEL_OP1: idx = opcode[3:2];
      cpu_pkg::SEL_SRC: idx = reg_src;
      // Illegal code, caught by the control assertion
      default:          idx = reg_src;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (load) begin
      regs[idx] <= bus_in;
    end
  end

  // Same index for read and write
  // Bus gating happens at the top level
  assign rd_data = regs[idx];

endmodule

//--- test/tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core;

  localparam int period_ns    = 4;
  localparam int reset_cycles = 16;
  // Reset, about 2048 boot writes, 40 instructions of up to 8 cycles, then doubled
  localparam int watchdog_ns  = 20000;
  localparam int wait_limit   = 40;

  // Opcode map of the test microprogram, fetch sits at opcode 0
  localparam logic [5:0] op_mov_in  = 6'h04;
  localparam logic [5:0] op_mov_out = 6'h08;
  localparam logic [5:0] op_mlu     = 6'h10;
  localparam logic [5:0] op_shift   = 6'h20;
  localparam logic [5:0] op_opword  = 6'h24;

  logic        clk;
  logic        rst_n;
  logic [7:0]  ext_data;
  logic [12:0] boot_addr;
  logic [7:0]  boot_data;
  logic        boot_we_n;
  logic        n_booted;
  logic        ext_rd;
  logic [7:0]  out_data;
  logic        out_valid;
  int          errors;
  int          checks;

  cpu_core #(.num_regs(4)) i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns with the tests still running", watchdog_ns);
    $display("Testbench failed");
    $finish;
  end

  // Control word from the field layout
  function automatic logic [31:0] make_word(input cpu_pkg::in_plane_e in_p,
      input cpu_pkg::out_plane_e out_p, input logic [3:0] alu, input logic misc);
    logic [31:0] w;
    w = '0;
    w[cpu_pkg::in_plane_lsb +: cpu_pkg::in_plane_width]   = in_p;
    w[cpu_pkg::out_plane_lsb +: cpu_pkg::out_plane_width] = out_p;
    w[cpu_pkg::alu_plane_lsb +: cpu_pkg::alu_plane_width] = alu;
    // reg_sel stays SEL_OP0, register index from opcode bits 1:0
    w[cpu_pkg::reg_sel_lsb +: cpu_pkg::reg_sel_width]     = cpu_pkg::SEL_OP0;
    w[cpu_pkg::misc_bit]                                  = misc;
    return w;
  endfunction

  // Truncated 8-bit results, cin in bit 0 of the ALU field
  function automatic logic [7:0] expected_mlu(input logic [3:0] k, input logic [7:0] a,
      input logic [7:0] b);
    case (cpu_pkg::mlu_op_e'(k[3:1]))
      cpu_pkg::MLU_ADD:  return 8'(int'(a) + int'(b) + int'(k[0]));
      cpu_pkg::MLU_SUB:  return 8'(int'(a) + int'(~b) + int'(k[0]));
      cpu_pkg::MLU_AND:  return a & b;
      cpu_pkg::MLU_OR:   return a | b;
      cpu_pkg::MLU_XOR:  return a ^ b;
      cpu_pkg::MLU_NOT:  return ~a;
      cpu_pkg::MLU_PASS: return a;
      default:           return 8'(int'(a) + 1);
    endcase
  endfunction

  function automatic logic [7:0] expected_shift(input cpu_pkg::shift_op_e sh,
      input logic [7:0] a);
    case (sh)
      cpu_pkg::SH_LSL: return {a[6:0], 1'b0};
      cpu_pkg::SH_LSR: return {1'b0, a[7:1]};
      default:         return {a[7], a[7:1]};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_quiet();
    checks++;
    assert (!out_valid && !ext_rd) else begin
      errors++;
      $display("ext_rd or out_valid went high during reset or before boot");
    end
  endtask

  // Lanes go in order 0 to 3, lane 0 is the low byte
  task automatic boot_word(input logic [5:0] op, input logic [4:0] st, input logic [31:0] w);
    for (int lane = 0; lane < 4; lane++) begin
      boot_addr = {op, st, 2'(lane)};
      boot_data = w[lane*8 +: 8];
      boot_we_n = 1'b0;
      @(posedge clk);
      #1;
      check_quiet();
    end
  endtask

  task automatic load_microcode();
    logic [31:0] end_w;
    end_w = make_word(cpu_pkg::IN_OPCODE, cpu_pkg::OUT_NONE, 4'h0, 1'b1);
    // Fetch loads the opcode and restarts the counter in one step
    boot_word(6'h00, 5'd0, make_word(cpu_pkg::IN_OPCODE, cpu_pkg::OUT_EXT, 4'h0, 1'b1));
    for (int r = 0; r < 4; r++) begin
      boot_word(op_mov_in | 6'(r), 5'd0, make_word(cpu_pkg::IN_REG, cpu_pkg::OUT_EXT, 4'h0, 1'b0));
      boot_word(op_mov_in | 6'(r), 5'd1, end_w);
      boot_word(op_mov_out | 6'(r), 5'd0,
                make_word(cpu_pkg::IN_OUTPORT, cpu_pkg::OUT_REG, 4'h0, 1'b0));
      boot_word(op_mov_out | 6'(r), 5'd1, end_w);
    end
    // One opcode per ALU field value
    for (int k = 0; k < 16; k++) begin
      boot_word(op_mlu | 6'(k), 5'd0, make_word(cpu_pkg::IN_TMP0, cpu_pkg::OUT_EXT, 4'h0, 1'b0));
      boot_word(op_mlu | 6'(k), 5'd1, make_word(cpu_pkg::IN_TMP1, cpu_pkg::OUT_EXT, 4'h0, 1'b0));
      boot_word(op_mlu | 6'(k), 5'd2,
                make_word(cpu_pkg::IN_OUTPORT, cpu_pkg::OUT_MLU, 4'(k), 1'b0));
      boot_word(op_mlu | 6'(k), 5'd3, end_w);
    end
    for (int s = 0; s < 3; s++) begin
      boot_word(op_shift | 6'(s), 5'd0, make_word(cpu_pkg::IN_TMP0, cpu_pkg::OUT_EXT, 4'h0, 1'b0));
      boot_word(op_shift | 6'(s), 5'd1,
                make_word(cpu_pkg::IN_OUTPORT, cpu_pkg::OUT_SHIFTER, 4'(s), 1'b0));
      boot_word(op_shift | 6'(s), 5'd2, end_w);
    end
    boot_word(op_opword, 5'd0, make_word(cpu_pkg::IN_OPWORD, cpu_pkg::OUT_EXT, 4'h0, 1'b0));
    boot_word(op_opword, 5'd1, make_word(cpu_pkg::IN_OUTPORT, cpu_pkg::OUT_OPWORD, 4'h0, 1'b0));
    boot_word(op_opword, 5'd2, end_w);
    boot_we_n = 1'b1;
  endtask

  // Byte is held until an edge with ext_rd high takes it
  task automatic feed_byte(input logic [7:0] b);
    int cnt;
    bit taken;
    cnt = 0;
    taken = 1'b0;
    ext_data = b;
    while (!taken && cnt < wait_limit) begin
      @(posedge clk);
      #1;
      taken = ext_rd;
      cnt++;
    end
    assert (taken) else begin
      errors++;
      $display("Byte %h was never read through ext_rd", b);
    end
    // Idle bus value, fetch of opcode 0 just loops
    ext_data = '0;
  endtask

  task automatic run_instr(input logic [5:0] op, input int n_ops, input logic [7:0] a,
      input logic [7:0] b, input bit want_out, output logic [7:0] res);
    int cnt;
    bit got;
    cnt = 0;
    got = 1'b0;
    res = '0;
    feed_byte({2'b00, op});
    if (n_ops > 0) feed_byte(a);
    if (n_ops > 1) feed_byte(b);
    while (want_out && !got && cnt < wait_limit) begin
      @(posedge clk);
      #1;
      got = out_valid;
      res = out_data;
      cnt++;
    end
    assert (!want_out || got) else begin
      errors++;
      $display("Opcode %h never raised out_valid", op);
    end
  endtask

  task automatic test_quiet_boot();
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clk);
      #1;
      // First edges still settle the negedge latch
      if (i >= 2) check_quiet();
    end
    rst_n = 1'b1;
    load_microcode();
    repeat (4) begin
      @(posedge clk);
      #1;
      check_quiet();
    end
    n_booted = 1'b0;
  endtask

  task automatic test_moves();
    logic [7:0] vals [4];
    logic [7:0] res;
    for (int r = 0; r < 4; r++) begin
      // Low bits carry the index so every register holds a distinct byte
      vals[r] = {6'($urandom), 2'(r)};
      run_instr(op_mov_in | 6'(r), 1, vals[r], 8'h00, 1'b0, res);
    end
    for (int r = 0; r < 4; r++) begin
      run_instr(op_mov_out | 6'(r), 0, 8'h00, 8'h00, 1'b1, res);
      check_value($sformatf("mov r%0d", r), vals[r], res);
    end
  endtask

  task automatic run_mlu(input cpu_pkg::mlu_op_e op, input logic cin);
    logic [3:0] k;
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] res;
    k = {op, cin};
    a = 8'($urandom);
    b = 8'($urandom);
    run_instr(op_mlu | 6'(k), 2, a, b, 1'b1, res);
    check_value($sformatf("%s cin=%0d", op.name(), cin), expected_mlu(k, a, b), res);
  endtask

  task automatic test_arith();
    run_mlu(cpu_pkg::MLU_ADD, 1'b0);
    run_mlu(cpu_pkg::MLU_ADD, 1'b1);
    run_mlu(cpu_pkg::MLU_SUB, 1'b0);
    run_mlu(cpu_pkg::MLU_SUB, 1'b1);
    run_mlu(cpu_pkg::MLU_INC, 1'b0);
  endtask

  task automatic test_logic();
    run_mlu(cpu_pkg::MLU_AND, 1'b0);
    run_mlu(cpu_pkg::MLU_OR, 1'b0);
    run_mlu(cpu_pkg::MLU_XOR, 1'b0);
    run_mlu(cpu_pkg::MLU_NOT, 1'b0);
    run_mlu(cpu_pkg::MLU_PASS, 1'b0);
  endtask

  task automatic test_shifts();
    cpu_pkg::shift_op_e sh;
    logic [7:0]         a;
    logic [7:0]         res;
    for (int s = 0; s < 3; s++) begin
      sh = cpu_pkg::shift_op_e'(2'(s));
      for (int n = 0; n < 2; n++) begin
        a = 8'($urandom);
        // Both sign values, so ASR replication is seen
        a[7] = (n == 1);
        run_instr(op_shift | 6'(s), 1, a, 8'h00, 1'b1, res);
        check_value($sformatf("%s a=%h", sh.name(), a), expected_shift(sh, a), res);
      end
    end
  endtask

  task automatic test_opword();
    logic [7:0] a;
    logic [7:0] res;
    repeat (2) begin
      a = 8'($urandom);
      run_instr(op_opword, 1, a, 8'h00, 1'b1, res);
      check_value("opword", a, res);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    ext_data  = '0;
    boot_addr = '0;
    boot_data = '0;
    boot_we_n = 1'b1;
    n_booted  = 1'b1;
    errors    = 0;
    checks    = 0;
    void'($urandom(32'hd544_7ff4));
    test_quiet_boot();
    test_moves();
    test_arith();
    test_logic();
    test_shifts();
    test_opword();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
